//--- src/board_ctrl_pkg.sv
//--------------------------------------------------
// board control package
// register word/address types, write and mdio structs, register map
//--------------------------------------------------
`default_nettype none

package board_ctrl_pkg;

    //--------------------------------------------------
    // widths
    //--------------------------------------------------
    localparam int ETH_PORTS = 4;               // one phy per port

    typedef logic [15:0]          reg_data_t;   // one register word
    typedef logic [6:0]           reg_addr_t;   // register index
    typedef logic [ETH_PORTS-1:0] eth_mask_t;   // per-port bit

    // write request, slave -> register file
    typedef struct packed {
        logic      en;      // one-cycle strobe
        reg_addr_t addr;
        reg_data_t data;
    } spi_wr_t;

    // bit-banged mdio pins, tristate sits outside
    typedef struct packed {
        logic mdc;
        logic data_o;
        logic dir;          // 1 = drive mdio
    } mdio_ctrl_t;

    //--------------------------------------------------
    // register map
    //--------------------------------------------------
    localparam reg_addr_t REG_FW_DATE_LO  = 7'd0;
    localparam reg_addr_t REG_FW_DATE_HI  = 7'd1;
    localparam reg_addr_t REG_FW_TIME_LO  = 7'd2;
    localparam reg_addr_t REG_FW_TIME_HI  = 7'd3;
    localparam reg_addr_t REG_FW_TYPE     = 7'd4;   // read only, constant
    localparam reg_addr_t REG_MAC_LINK    = 7'd5;   // read only, link status
    localparam reg_addr_t REG_PHY_RST     = 7'd8;   // bits 3:0
    localparam reg_addr_t REG_MDIO_CLK    = 7'd9;
    localparam reg_addr_t REG_MDIO_DATA_O = 7'd10;
    localparam reg_addr_t REG_MDIO_DIR    = 7'd11;
    localparam reg_addr_t REG_MDIO_DATA_I = 7'd12;  // read only, pin state
    localparam reg_addr_t REG_TEST_BASE   = 7'd16;  // scratch array start

    localparam reg_data_t FW_TYPE_WORD = 16'h0001;

    // address byte bit 7 set = read frame
    localparam int SPI_RD_BIT = 7;

endpackage

`default_nettype wire

//--- src/spi_reg_slave.sv
//--------------------------------------------------
// spi mode-0 register slave, oversampled on clk125M
// 8 bit address + 16 bit data frames -> write strobe / read reply
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module spi_reg_slave (
    input  wire                            clk125M,
    input  wire                            arst_n_i,
    input  wire                            spi_sclk_i,
    input  wire                            spi_cs_n_i,   // active low
    input  wire                            spi_mosi_i,
    input  wire board_ctrl_pkg::reg_data_t rd_data_i,    // comb. from reg file
    output logic                           spi_miso_o,
    output board_ctrl_pkg::spi_wr_t        wr_o,
    output board_ctrl_pkg::reg_addr_t      rd_addr_o
);

    localparam logic [4:0] ADDR_LAST  = 5'd7;    // last address bit
    localparam logic [4:0] DATA_FIRST = 5'd8;
    localparam logic [4:0] LAST_BIT   = 5'd23;   // data bit 0

    typedef enum logic [1:0] {
        PH_ADDR,    // shifting in address byte
        PH_WDATA,   // write data phase
        PH_RDATA    // read data phase, miso active
    } phase_t;

    phase_t phase;

    logic [1:0] sclk_sync;
    logic [1:0] cs_n_sync;
    logic [1:0] mosi_sync;
    logic       sclk_prev;
    logic       cs_act;
    logic       mosi_bit;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [4:0] bit_cnt;            // position within frame, 0..23
    logic [14:0] rx_shift;
    logic [7:0] addr_byte;
    logic       rd_load;            // cycle after address of a read
    logic       wr_en_q;
    board_ctrl_pkg::reg_data_t wr_data_q;
    board_ctrl_pkg::reg_data_t tx_shift;

    //--------------------------------------------------
    // pin synchronizers and edge detect
    //--------------------------------------------------
    always_ff @(posedge clk125M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sclk_sync <= '0;
            cs_n_sync <= 2'b11;     // deselected
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk_i};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign cs_act    = ~cs_n_sync[1];
    assign mosi_bit  = mosi_sync[1];
    assign sclk_rise = cs_act &  sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = cs_act & ~sclk_sync[1] &  sclk_prev;
    assign addr_byte = {rx_shift[6:0], mosi_bit};   // complete on bit 7

    //--------------------------------------------------
    // frame control
    //--------------------------------------------------
    always_ff @(posedge clk125M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bit_cnt   <= '0;
            phase     <= PH_ADDR;
            rd_load   <= 1'b0;
            wr_en_q   <= 1'b0;
            rd_addr_o <= '0;
        end else begin
            rd_load <= 1'b0;
            wr_en_q <= 1'b0;
            if (!cs_act) begin
                // cs high aborts, restart at bit 0
                bit_cnt <= '0;
                phase   <= PH_ADDR;
            end else if (sclk_rise) begin
                if (bit_cnt == LAST_BIT) begin
                    bit_cnt <= '0;
                    phase   <= PH_ADDR;
                    wr_en_q <= (phase == PH_WDATA);   // strobe on data bit 0
                end else begin
                    bit_cnt <= bit_cnt + 5'd1;
                end
                if (bit_cnt == ADDR_LAST) begin
                    rd_addr_o <= addr_byte[6:0];      // held until next frame
                    rd_load   <= addr_byte[board_ctrl_pkg::SPI_RD_BIT];
                    phase     <= addr_byte[board_ctrl_pkg::SPI_RD_BIT] ? PH_RDATA : PH_WDATA;
                end
            end
        end
    end

    //--------------------------------------------------
    // shift registers
    //--------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[13:0], mosi_bit};   // msb first
        end
        if (sclk_rise && bit_cnt == LAST_BIT) begin
            wr_data_q <= {rx_shift, mosi_bit};
        end
        // read word snapshot, then one bit per falling edge
        if (rd_load) begin
            tx_shift <= rd_data_i;
        end else if (sclk_fall && bit_cnt > DATA_FIRST) begin
            tx_shift <= {tx_shift[14:0], 1'b0};
        end
    end

    // miso low outside read data phase
    assign spi_miso_o = (phase == PH_RDATA) & ~rd_load & tx_shift[15];

    assign wr_o = '{en: wr_en_q, addr: rd_addr_o, data: wr_data_q};

    //--------------------------------------------------
    // checks
    //--------------------------------------------------
    a_wr_single : assert property (@(posedge clk125M) disable iff (!arst_n_i)
        wr_en_q |=> !wr_en_q)
        else $error("spi_reg_slave: write strobe high two cycles in a row");

    a_bit_cnt : assert property (@(posedge clk125M) disable iff (!arst_n_i)
        bit_cnt < 5'd24)
        else $error("spi_reg_slave: bit count out of frame");

endmodule

`default_nettype wire

//--- src/ctrl_reg_file.sv
//--------------------------------------------------
// board control register file
// write decode, phy reset / mdio outputs, test array, read mux
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ctrl_reg_file #(
    parameter logic [31:0] FW_DATE        = 32'h0,
    parameter logic [31:0] FW_TIME        = 32'h0,
    parameter int          TEST_REG_COUNT = 8       // 1..16
) (
    input  wire                            clk125M,
    input  wire                            arst_n_i,
    input  wire board_ctrl_pkg::spi_wr_t   wr_i,
    input  wire board_ctrl_pkg::reg_addr_t rd_addr_i,
    input  wire board_ctrl_pkg::eth_mask_t mac_link_i,
    input  wire                            mdio_i,      // raw pin
    output board_ctrl_pkg::reg_data_t      rd_data_o,
    output board_ctrl_pkg::eth_mask_t      eth_phy_rst_o,
    output board_ctrl_pkg::mdio_ctrl_t     mdio_o
);

    localparam int ETH_PORTS = board_ctrl_pkg::ETH_PORTS;

    board_ctrl_pkg::reg_data_t test_q [TEST_REG_COUNT];   // scratch array
    logic [1:0] mdio_sync;                                // pin is async

    //--------------------------------------------------
    // write decode
    //--------------------------------------------------
    always_ff @(posedge clk125M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            eth_phy_rst_o <= '0;
            mdio_o        <= '0;
            for (int i = 0; i < TEST_REG_COUNT; i++) begin
                test_q[i] <= '0;
            end
        end else if (wr_i.en) begin
            case (wr_i.addr)
                board_ctrl_pkg::REG_PHY_RST:     eth_phy_rst_o <= wr_i.data[ETH_PORTS-1:0];
                board_ctrl_pkg::REG_MDIO_CLK:    mdio_o.mdc    <= wr_i.data[0];
                board_ctrl_pkg::REG_MDIO_DATA_O: mdio_o.data_o <= wr_i.data[0];
                board_ctrl_pkg::REG_MDIO_DIR:    mdio_o.dir    <= wr_i.data[0];
                default: ;  // read only / unmapped, dropped
            endcase
            for (int i = 0; i < TEST_REG_COUNT; i++) begin
                if (wr_i.addr == board_ctrl_pkg::reg_addr_t'(board_ctrl_pkg::REG_TEST_BASE + i)) begin
                    test_q[i] <= wr_i.data;
                end
            end
        end
    end

    // mdio input readback
    always_ff @(posedge clk125M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mdio_sync <= '0;
        end else begin
            mdio_sync <= {mdio_sync[0], mdio_i};
        end
    end

    //--------------------------------------------------
    // read mux, comb. so no wait on the spi side
    //--------------------------------------------------
    always_comb begin
        rd_data_o = '0;     // unmapped reads 0
        case (rd_addr_i)
            board_ctrl_pkg::REG_FW_DATE_LO:  rd_data_o = FW_DATE[15:0];
            board_ctrl_pkg::REG_FW_DATE_HI:  rd_data_o = FW_DATE[31:16];
            board_ctrl_pkg::REG_FW_TIME_LO:  rd_data_o = FW_TIME[15:0];
            board_ctrl_pkg::REG_FW_TIME_HI:  rd_data_o = FW_TIME[31:16];
            board_ctrl_pkg::REG_FW_TYPE:     rd_data_o = board_ctrl_pkg::FW_TYPE_WORD;
            board_ctrl_pkg::REG_MAC_LINK: begin
                rd_data_o[ETH_PORTS-1:0] = mac_link_i;
            end
            board_ctrl_pkg::REG_PHY_RST: begin
                rd_data_o[ETH_PORTS-1:0] = eth_phy_rst_o;
            end
            board_ctrl_pkg::REG_MDIO_CLK:    rd_data_o[0] = mdio_o.mdc;
            board_ctrl_pkg::REG_MDIO_DATA_O: rd_data_o[0] = mdio_o.data_o;
            board_ctrl_pkg::REG_MDIO_DIR:    rd_data_o[0] = mdio_o.dir;
            board_ctrl_pkg::REG_MDIO_DATA_I: rd_data_o[0] = mdio_sync[1];
            default: ;
        endcase
        // scratch array, TEST_REG_COUNT words from base
        for (int i = 0; i < TEST_REG_COUNT; i++) begin
            if (rd_addr_i == board_ctrl_pkg::reg_addr_t'(board_ctrl_pkg::REG_TEST_BASE + i)) begin
                rd_data_o = test_q[i];
            end
        end
    end

    //--------------------------------------------------
    // checks
    //--------------------------------------------------
    a_wr_addr_known : assert property (@(posedge clk125M) disable iff (!arst_n_i)
        wr_i.en |-> !$isunknown(wr_i.addr))
        else $error("ctrl_reg_file: write strobe with unknown address");

endmodule

`default_nettype wire

//--- src/led_blink_timer.sv
//--------------------------------------------------
// debug led blinker, clk -> us -> ms prescaler
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module led_blink_timer #(
    parameter int CLK_PER_US    = 125,  // clk125M cycles per us
    parameter int BLINK_HALF_MS = 125   // led half period in ms
) (
    input  wire  clk125M,
    input  wire  arst_n_i,
    output logic dbg_led_o
);

    localparam int US_PER_MS = 1000;
    localparam int CLK_W     = $clog2(CLK_PER_US + 1);
    localparam int US_W      = $clog2(US_PER_MS + 1);
    localparam int MS_W      = $clog2(BLINK_HALF_MS + 1);

    logic [CLK_W-1:0] clk_cnt;
    logic [US_W-1:0]  us_cnt;
    logic [MS_W-1:0]  ms_cnt;
    logic             us_tick;
    logic             ms_tick;

    assign us_tick = (clk_cnt == CLK_W'(CLK_PER_US - 1));
    assign ms_tick = us_tick && (us_cnt == US_W'(US_PER_MS - 1));

    always_ff @(posedge clk125M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            clk_cnt   <= '0;
            us_cnt    <= '0;
            ms_cnt    <= '0;
            dbg_led_o <= 1'b0;
        end else begin
            clk_cnt <= us_tick ? '0 : clk_cnt + 1'b1;   // wraps each us
            if (us_tick) begin
                us_cnt <= ms_tick ? '0 : us_cnt + 1'b1; // wraps each ms
            end
            if (ms_tick) begin
                if (ms_cnt == MS_W'(BLINK_HALF_MS - 1)) begin
                    ms_cnt    <= '0;
                    dbg_led_o <= ~dbg_led_o;            // half period done
                end else begin
                    ms_cnt <= ms_cnt + 1'b1;
                end
            end
        end
    end

    a_cnt_range : assert property (@(posedge clk125M) disable iff (!arst_n_i)
        (clk_cnt < CLK_W'(CLK_PER_US)) && (us_cnt < US_W'(US_PER_MS))
        && (ms_cnt < MS_W'(BLINK_HALF_MS)))
        else $error("led_blink_timer: counter past its limit");

endmodule

`default_nettype wire

//--- src/board_ctrl_top.sv
//--------------------------------------------------
// board control top, spi slave + register file + led timer
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module board_ctrl_top #(
    parameter logic [31:0] FW_DATE        = 32'h0,
    parameter logic [31:0] FW_TIME        = 32'h0,
    parameter int          TEST_REG_COUNT = 8,
    parameter int          CLK_PER_US     = 125,
    parameter int          BLINK_HALF_MS  = 125
) (
    input  wire                            clk125M,
    input  wire                            arst_n_i,
    input  wire                            usr_spi_sclk_i,
    input  wire                            usr_spi_cs_n_i,
    input  wire                            usr_spi_mosi_i,
    input  wire board_ctrl_pkg::eth_mask_t mac_link_i,
    input  wire                            eth_phy_mdio_i,
    output logic                           usr_spi_miso_o,
    output board_ctrl_pkg::eth_mask_t      eth_phy_rst_o,
    output logic                           eth_phy_mdc_o,
    output logic                           eth_phy_mdio_o,
    output logic                           eth_phy_mdio_oe_o,  // to external tristate
    output logic                           dbg_led_o
);

    board_ctrl_pkg::spi_wr_t    spi_wr;     // write strobe + addr/data
    board_ctrl_pkg::reg_addr_t  rd_addr;
    board_ctrl_pkg::reg_data_t  rd_data;
    board_ctrl_pkg::mdio_ctrl_t mdio_ctrl;

    //--------------------------------------------------
    // user spi -> registers
    //--------------------------------------------------
    spi_reg_slave u_spi (
        .clk125M    (clk125M),
        .arst_n_i   (arst_n_i),
        .spi_sclk_i (usr_spi_sclk_i),
        .spi_cs_n_i (usr_spi_cs_n_i),
        .spi_mosi_i (usr_spi_mosi_i),
        .rd_data_i  (rd_data),
        .spi_miso_o (usr_spi_miso_o),
        .wr_o       (spi_wr),
        .rd_addr_o  (rd_addr)
    );

    ctrl_reg_file #(
        .FW_DATE        (FW_DATE),
        .FW_TIME        (FW_TIME),
        .TEST_REG_COUNT (TEST_REG_COUNT)
    ) u_regs (
        .clk125M       (clk125M),
        .arst_n_i      (arst_n_i),
        .wr_i          (spi_wr),
        .rd_addr_i     (rd_addr),
        .mac_link_i    (mac_link_i),
        .mdio_i        (eth_phy_mdio_i),
        .rd_data_o     (rd_data),
        .eth_phy_rst_o (eth_phy_rst_o),
        .mdio_o        (mdio_ctrl)
    );

    // mdio struct out to pins
    assign eth_phy_mdc_o     = mdio_ctrl.mdc;
    assign eth_phy_mdio_o    = mdio_ctrl.data_o;
    assign eth_phy_mdio_oe_o = mdio_ctrl.dir;

    //--------------------------------------------------
    // debug led
    //--------------------------------------------------
    led_blink_timer #(
        .CLK_PER_US    (CLK_PER_US),
        .BLINK_HALF_MS (BLINK_HALF_MS)
    ) u_led (
        .clk125M   (clk125M),
        .arst_n_i  (arst_n_i),
        .dbg_led_o (dbg_led_o)
    );

endmodule

`default_nettype wire

//--- test/spi_bfm_tasks.svh
//--------------------------------------------------
// spi mode-0 master frame task, galois lfsr, led edge wait
//--------------------------------------------------
`ifndef SPI_BFM_TASKS_SVH
`define SPI_BFM_TASKS_SVH

    // one 24 bit frame, caller sits on a falling clk edge
    task automatic spi_frame(input logic rd, input board_ctrl_pkg::reg_addr_t addr,
                             input board_ctrl_pkg::reg_data_t wdata,
                             output board_ctrl_pkg::reg_data_t rdata);
        logic [23:0] frame;
        frame = {rd, addr, wdata};                  // msb first
        rdata = '0;
        usr_spi_cs_n_i = 1'b0;
        repeat (SCLK_HALF) @(negedge clk125M);
        for (int i = 23; i >= 0; i--) begin
            usr_spi_mosi_i = frame[i];              // set up while sclk low
            repeat (SCLK_HALF) @(negedge clk125M);
            usr_spi_sclk_i = 1'b1;
            if (i < 16) begin
                rdata = {rdata[14:0], usr_spi_miso_o};  // data phase, sampled on rise
            end
            repeat (SCLK_HALF) @(negedge clk125M);
            usr_spi_sclk_i = 1'b0;
        end
        repeat (SCLK_HALF) @(negedge clk125M);
        usr_spi_cs_n_i = 1'b1;
        usr_spi_mosi_i = 1'b0;
        repeat (2 * SCLK_HALF) @(negedge clk125M);  // idle gap
    endtask

    // galois lfsr, shifts right, one step per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]};
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic board_ctrl_pkg::reg_data_t lfsr_word();
        board_ctrl_pkg::reg_data_t w;
        logic b;
        w = '0;
        for (int n = 0; n < 16; n++) begin
            b = lfsr_bit();
            w = {w[14:0], b};
        end
        return w;
    endfunction

    // wait for the led to change, counts clk cycles, gives up at limit
    task automatic wait_led_edge(input int limit, output int cycles, output logic seen);
        logic start;
        start = dbg_led_o;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk125M);
            cycles++;
            seen = (dbg_led_o != start);
        end
    endtask

`endif

//--- test/board_ctrl_tb.sv
//--------------------------------------------------
// board control testbench
// spi register table, pin checks, led interval check
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module board_ctrl_tb;

    localparam int CLK_PER_US    = 4;
    localparam int BLINK_HALF_MS = 3;
    localparam int TEST_REGS     = 8;
    localparam int LED_HALF      = CLK_PER_US * 1000 * BLINK_HALF_MS;  // cycles per led level
    localparam int SCLK_HALF     = 5;                   // clk cycles per sclk level
    localparam logic [15:0] LFSR_SEED = 16'd36366;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;       // x^16+x^14+x^13+x^11+1
    localparam logic RD = 1'b1;
    localparam logic WR = 1'b0;

    // frame, expected reply and pins, inputs applied during the frame
    typedef struct packed {
        logic                      rd;
        board_ctrl_pkg::reg_addr_t addr;
        board_ctrl_pkg::reg_data_t wdata;
        board_ctrl_pkg::reg_data_t exp_rd;
        board_ctrl_pkg::eth_mask_t exp_rst;
        logic [2:0]                exp_mdio;    // mdc, mdio, oe
        board_ctrl_pkg::eth_mask_t link;
        logic                      mdio_in;
    } row_t;

    logic                      clk125M = 1'b0;
    logic                      arst_n_i;
    logic                      usr_spi_sclk_i;
    logic                      usr_spi_cs_n_i;
    logic                      usr_spi_mosi_i;
    board_ctrl_pkg::eth_mask_t mac_link_i;
    logic                      eth_phy_mdio_i;
    logic                      usr_spi_miso_o;
    board_ctrl_pkg::eth_mask_t eth_phy_rst_o;
    logic                      eth_phy_mdc_o;
    logic                      eth_phy_mdio_o;
    logic                      eth_phy_mdio_oe_o;
    logic                      dbg_led_o;

    logic [15:0] lfsr_state;
    row_t        rows [$];
    int          rd_err  = 0;
    int          pin_err = 0;
    int          led_err = 0;

    always #4 clk125M = ~clk125M;   // 8 ns period

    board_ctrl_top #(
        .FW_DATE        (32'h20240611),
        .FW_TIME        (32'h00153000),
        .TEST_REG_COUNT (TEST_REGS),
        .CLK_PER_US     (CLK_PER_US),
        .BLINK_HALF_MS  (BLINK_HALF_MS)
    ) UUT (.*);

    `include "spi_bfm_tasks.svh"

    function automatic void add_row(input logic rd, input board_ctrl_pkg::reg_addr_t addr,
            input board_ctrl_pkg::reg_data_t wdata, input board_ctrl_pkg::reg_data_t exp_rd,
            input board_ctrl_pkg::eth_mask_t exp_rst, input logic [2:0] exp_mdio,
            input board_ctrl_pkg::eth_mask_t link, input logic mdio_in);
        row_t row;
        row = '{rd, addr, wdata, exp_rd, exp_rst, exp_mdio, link, mdio_in};
        rows.push_back(row);
    endfunction

    //--------------------------------------------------
    // stimulus table
    //--------------------------------------------------
    function automatic void build_table();
        // reset state, firmware words
        add_row(RD, 7'd0,   16'h0000, 16'h0611, 4'h0, 3'b000, 4'h0, 1'b0);  // date lo
        add_row(RD, 7'd1,   16'h0000, 16'h2024, 4'h0, 3'b000, 4'h0, 1'b0);  // date hi
        add_row(RD, 7'd2,   16'h0000, 16'h3000, 4'h0, 3'b000, 4'h0, 1'b0);  // time lo
        add_row(RD, 7'd3,   16'h0000, 16'h0015, 4'h0, 3'b000, 4'h0, 1'b0);  // time hi
        add_row(RD, 7'd4,   16'h0000, 16'h0001, 4'h0, 3'b000, 4'h0, 1'b0);  // fw type
        add_row(RD, 7'd8,   16'h0000, 16'h0000, 4'h0, 3'b000, 4'h0, 1'b0);
        add_row(RD, 7'd9,   16'h0000, 16'h0000, 4'h0, 3'b000, 4'h0, 1'b0);
        add_row(RD, 7'd10,  16'h0000, 16'h0000, 4'h0, 3'b000, 4'h0, 1'b0);
        add_row(RD, 7'd11,  16'h0000, 16'h0000, 4'h0, 3'b000, 4'h0, 1'b0);
        // scratch array, data and expects filled in later
        for (int i = 0; i < TEST_REGS; i++) begin
            add_row(WR, 7'(16 + i), 16'h0000, 16'h0000, 4'h0, 3'b000, 4'h0, 1'b0);
        end
        for (int i = 0; i < TEST_REGS; i++) begin
            add_row(RD, 7'(16 + i), 16'h0000, 16'h0000, 4'h0, 3'b000, 4'h0, 1'b0);
        end
        add_row(RD, 7'd6,   16'h0000, 16'h0000, 4'h0, 3'b000, 4'h0, 1'b0);  // unmapped
        add_row(RD, 7'd24,  16'h0000, 16'h0000, 4'h0, 3'b000, 4'h0, 1'b0);  // past array
        add_row(RD, 7'd127, 16'h0000, 16'h0000, 4'h0, 3'b000, 4'h0, 1'b0);
        // phy reset keeps 3:0, mdio bits keep bit 0
        add_row(WR, 7'd8,   16'hA5C3, 16'h0000, 4'h3, 3'b000, 4'h0, 1'b0);
        add_row(RD, 7'd8,   16'h0000, 16'h0003, 4'h3, 3'b000, 4'h0, 1'b0);
        add_row(WR, 7'd8,   16'h123C, 16'h0000, 4'hC, 3'b000, 4'h0, 1'b0);
        add_row(WR, 7'd9,   16'hFFFF, 16'h0000, 4'hC, 3'b100, 4'h0, 1'b0);  // mdc
        add_row(RD, 7'd9,   16'h0000, 16'h0001, 4'hC, 3'b100, 4'h0, 1'b0);
        add_row(WR, 7'd10,  16'h0003, 16'h0000, 4'hC, 3'b110, 4'h0, 1'b0);  // mdio out
        add_row(RD, 7'd10,  16'h0000, 16'h0001, 4'hC, 3'b110, 4'h0, 1'b0);
        add_row(WR, 7'd11,  16'h8001, 16'h0000, 4'hC, 3'b111, 4'h0, 1'b0);  // oe
        add_row(RD, 7'd11,  16'h0000, 16'h0001, 4'hC, 3'b111, 4'h0, 1'b0);
        add_row(WR, 7'd9,   16'hFFFE, 16'h0000, 4'hC, 3'b011, 4'h0, 1'b0);
        add_row(RD, 7'd9,   16'h0000, 16'h0000, 4'hC, 3'b011, 4'h0, 1'b0);
        // status inputs, writes to read-only words
        add_row(RD, 7'd5,   16'h0000, 16'h000A, 4'hC, 3'b011, 4'hA, 1'b0);  // link
        add_row(RD, 7'd12,  16'h0000, 16'h0001, 4'hC, 3'b011, 4'hA, 1'b1);  // mdio in
        add_row(RD, 7'd12,  16'h0000, 16'h0000, 4'hC, 3'b011, 4'hA, 1'b0);
        add_row(WR, 7'd4,   16'hBEEF, 16'h0000, 4'hC, 3'b011, 4'h3, 1'b0);
        add_row(RD, 7'd4,   16'h0000, 16'h0001, 4'hC, 3'b011, 4'h3, 1'b0);
        add_row(WR, 7'd5,   16'hFFFF, 16'h0000, 4'hC, 3'b011, 4'h3, 1'b0);
        add_row(RD, 7'd5,   16'h0000, 16'h0003, 4'hC, 3'b011, 4'h3, 1'b0);
    endfunction

    // lfsr data into scratch writes, model feeds the read expects
    function automatic void fill_test_data();
        board_ctrl_pkg::reg_data_t model [TEST_REGS];
        row_t row;
        int   idx;
        foreach (model[k]) model[k] = '0;
        foreach (rows[r]) begin
            row = rows[r];
            idx = int'(row.addr) - int'(board_ctrl_pkg::REG_TEST_BASE);
            if (idx >= 0 && idx < TEST_REGS) begin
                if (row.rd) begin
                    row.exp_rd = model[idx];
                end else begin
                    row.wdata  = lfsr_word();
                    model[idx] = row.wdata;
                end
                rows[r] = row;
            end
        end
    endfunction

    task automatic check_pins(input board_ctrl_pkg::eth_mask_t exp_rst,
                              input logic [2:0] exp_mdio, input string tag);
        if (eth_phy_rst_o !== exp_rst) begin
            $display("Error: eth_phy_rst_o %s got 0x%h exp 0x%h", tag, eth_phy_rst_o, exp_rst);
            pin_err++;
        end
        if ({eth_phy_mdc_o, eth_phy_mdio_o, eth_phy_mdio_oe_o} !== exp_mdio) begin
            $display("Error: eth_phy_mdc_o/mdio_o/mdio_oe_o %s got 0x%h exp 0x%h", tag,
                     {eth_phy_mdc_o, eth_phy_mdio_o, eth_phy_mdio_oe_o}, exp_mdio);
            pin_err++;
        end
    endtask

    task automatic run_row(input row_t row, input int idx);
        board_ctrl_pkg::reg_data_t got;
        mac_link_i     = row.link;
        eth_phy_mdio_i = row.mdio_in;
        spi_frame(row.rd, row.addr, row.wdata, got);
        if (row.rd && got !== row.exp_rd) begin
            $display("Error: usr_spi_miso_o row %0d addr 0x%h got 0x%h exp 0x%h",
                     idx, row.addr, got, row.exp_rd);
            rd_err++;
        end
        if (!row.rd && got !== 16'h0000) begin      // miso quiet in write frames
            $display("Error: usr_spi_miso_o row %0d write got 0x%h exp 0x0000", idx, got);
            rd_err++;
        end
        check_pins(row.exp_rst, row.exp_mdio, $sformatf("row %0d", idx));
    endtask

    // sync to one led edge, then time three half periods
    task automatic check_led();
        int   cycles;
        logic seen;
        wait_led_edge(LED_HALF + 100, cycles, seen);
        for (int n = 0; n < 3 && seen; n++) begin
            wait_led_edge(LED_HALF + 100, cycles, seen);
            if (seen && cycles != LED_HALF) begin
                $display("Error: dbg_led_o interval %0d got 0x%h exp 0x%h cycles",
                         n, cycles, LED_HALF);
                led_err++;
            end
        end
        if (!seen) begin
            $display("LED did not toggle within %0d clock cycles", LED_HALF + 100);
            led_err++;
        end
    endtask

    //--------------------------------------------------
    // main sequence
    //--------------------------------------------------
    initial begin
        arst_n_i       = 1'b0;
        usr_spi_sclk_i = 1'b0;
        usr_spi_cs_n_i = 1'b1;
        usr_spi_mosi_i = 1'b0;
        mac_link_i     = '0;
        eth_phy_mdio_i = 1'b0;
        lfsr_state     = LFSR_SEED;
        build_table();
        fill_test_data();
        repeat (2) @(negedge clk125M);              // 2 cycles of reset
        arst_n_i = 1'b1;
        @(negedge clk125M);
        check_pins(4'h0, 3'b000, "after reset");
        if (dbg_led_o !== 1'b0) begin
            $display("Error: dbg_led_o after reset got 0x%h exp 0x0", dbg_led_o);
            led_err++;
        end
        foreach (rows[r]) begin
            run_row(rows[r], r);
        end
        check_led();
        $display("Summary: %0d read errors, %0d pin errors, %0d timer errors",
                 rd_err, pin_err, led_err);
        if (rd_err + pin_err + led_err == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/board_ctrl_pkg.sv
src/spi_reg_slave.sv
src/ctrl_reg_file.sv
src/led_blink_timer.sv
src/board_ctrl_top.sv
+incdir+test
test/board_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the board control testbench with verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module board_ctrl_tb -o board_ctrl_sim
./obj_dir/board_ctrl_sim | tee sim.log

# verdict comes from the log
if grep -q "Checks failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
